// File: logic/axi_rd_settings.svh
//--------------------------------------------------------------------
// Width, depth and fetch delay settings of the AXI read slave
//--------------------------------------------------------------------
`ifndef AXI_RD_SETTINGS_SVH
`define AXI_RD_SETTINGS_SVH

// AXI field widths
`define AXI_RD_ID_W       4
`define AXI_RD_ADDR_W     16
`define AXI_RD_DATA_W     32
`define AXI_RD_LEN_W      8
`define AXI_RD_SIZE_W     3

// Outstanding requests held in the AR queue, power of two
`define AXI_RD_OST_DEPTH  4

// Modelled memory latency per beat, in cycles
`define AXI_RD_FETCH_DLY  18

`endif

// File: logic/axi_rd_pkg.sv
//--------------------------------------------------------------------
// Shared types and codes of the AXI read slave
//--------------------------------------------------------------------
`default_nettype none

`include "axi_rd_settings.svh"

package axi_rd_pkg;

    // Field vectors
    typedef logic [`AXI_RD_ID_W-1:0]   axi_id_t;
    typedef logic [`AXI_RD_ADDR_W-1:0] axi_addr_t;
    typedef logic [`AXI_RD_DATA_W-1:0] axi_data_t;
    typedef logic [`AXI_RD_LEN_W-1:0]  axi_len_t;
    typedef logic [`AXI_RD_SIZE_W-1:0] axi_size_t;

    // Burst type encoding
    typedef logic [1:0] axi_burst_t;
    localparam axi_burst_t BURST_FIXED = 2'b00;
    localparam axi_burst_t BURST_INCR  = 2'b01;
    localparam axi_burst_t BURST_WRAP  = 2'b10;

    // Read response encoding
    typedef logic [1:0] axi_resp_t;
    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // Request queue pointer
    typedef logic [$clog2(`AXI_RD_OST_DEPTH)-1:0] ost_ptr_t;

    // Per-beat memory fetch FSM
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_WAIT,
        FETCH_READY
    } fetch_state_t;

endpackage

`default_nettype wire

// File: logic/rd_req_queue.sv
//--------------------------------------------------------------------
// Circular queue of outstanding AR requests with head entry output
//--------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "axi_rd_settings.svh"

module rd_req_queue (
    input  logic                   clk,
    input  logic                   rst_n,
    // AR channel
    input  logic                   arvalid,
    output logic                   arready,
    input  axi_rd_pkg::axi_id_t    arid,
    input  axi_rd_pkg::axi_addr_t  araddr,
    input  axi_rd_pkg::axi_len_t   arlen,
    input  axi_rd_pkg::axi_size_t  arsize,
    input  axi_rd_pkg::axi_burst_t arburst,
    // Completion of the head request
    input  logic                   burst_done,
    // Head entry
    output logic                   head_valid,
    output axi_rd_pkg::axi_id_t    head_id,
    output axi_rd_pkg::axi_addr_t  head_addr,
    output axi_rd_pkg::axi_len_t   head_len,
    output axi_rd_pkg::axi_size_t  head_size,
    output axi_rd_pkg::axi_burst_t head_burst
);
    import axi_rd_pkg::*;

    localparam int DEPTH = `AXI_RD_OST_DEPTH;

    logic [DEPTH-1:0] entry_valid;
    ost_ptr_t         wr_ptr;
    ost_ptr_t         rd_ptr;
    logic             push;
    logic             pop;

    // Request payload storage
    axi_id_t          id_mem    [DEPTH];
    axi_addr_t        addr_mem  [DEPTH];
    axi_len_t         len_mem   [DEPTH];
    axi_size_t        size_mem  [DEPTH];
    axi_burst_t       burst_mem [DEPTH];

    assign arready = ~&entry_valid;
    assign push    = arvalid & arready;
    assign pop     = burst_done & head_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
            wr_ptr      <= '0;
            rd_ptr      <= '0;
        end else begin
            if (push) begin
                entry_valid[wr_ptr] <= 1'b1;
                wr_ptr              <= wr_ptr + ost_ptr_t'(1);
            end
            // Never the same slot as a push, the queue is not empty here
            if (pop) begin
                entry_valid[rd_ptr] <= 1'b0;
                rd_ptr              <= rd_ptr + ost_ptr_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            id_mem[wr_ptr]    <= arid;
            addr_mem[wr_ptr]  <= araddr;
            len_mem[wr_ptr]   <= arlen;
            size_mem[wr_ptr]  <= arsize;
            burst_mem[wr_ptr] <= arburst;
        end
    end

    // Oldest request is served first
    assign head_valid = entry_valid[rd_ptr];
    assign head_id    = id_mem[rd_ptr];
    assign head_addr  = addr_mem[rd_ptr];
    assign head_len   = len_mem[rd_ptr];
    assign head_size  = size_mem[rd_ptr];
    assign head_burst = burst_mem[rd_ptr];

endmodule

`default_nettype wire

// File: logic/beat_addr_gen.sv
//--------------------------------------------------------------------
// Beat address, beat index and last flag of the head request
//--------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module beat_addr_gen (
    input  logic                   clk,
    input  logic                   rst_n,
    // Head request
    input  logic                   head_valid,
    input  axi_rd_pkg::axi_addr_t  head_addr,
    input  axi_rd_pkg::axi_len_t   head_len,
    input  axi_rd_pkg::axi_size_t  head_size,
    input  axi_rd_pkg::axi_burst_t head_burst,
    // R channel progress
    input  logic                   beat_done,
    input  logic                   burst_done,
    // Current beat
    output axi_rd_pkg::axi_addr_t  beat_addr,
    output logic                   beat_last
);
    import axi_rd_pkg::*;

    axi_len_t  beat_idx;
    logic      wrapped;
    axi_addr_t cur_addr;

    axi_addr_t bytes;
    axi_addr_t aligned_start;
    axi_addr_t container;
    axi_addr_t wrap_low;
    axi_addr_t wrap_high;
    axi_addr_t next_lin;
    axi_addr_t next_addr;
    logic      is_wrap;
    logic      wrap_hit;

    //----------------------------------------------------------------
    // Burst geometry
    //----------------------------------------------------------------
    assign bytes         = axi_addr_t'(1) << head_size;
    assign aligned_start = head_addr & ~(bytes - axi_addr_t'(1));
    // WRAP lengths are powers of two, so the container is one too
    assign container     = (axi_addr_t'(head_len) + axi_addr_t'(1)) << head_size;
    assign wrap_low      = head_addr & ~(container - axi_addr_t'(1));
    assign wrap_high     = wrap_low + container;

    // Address of the following beat as if the burst never wrapped
    assign next_lin = aligned_start + ((axi_addr_t'(beat_idx) + axi_addr_t'(1)) << head_size);
    assign is_wrap  = (head_burst == BURST_WRAP);
    assign wrap_hit = ~wrapped & (next_lin == wrap_high);

    always_comb begin
        case (head_burst)
            BURST_FIXED: next_addr = head_addr;
            BURST_INCR:  next_addr = next_lin;
            // Once past the upper end, fold back by one container
            BURST_WRAP:  next_addr = (wrapped | wrap_hit) ? next_lin - container : next_lin;
            default:     next_addr = next_lin;
        endcase
    end

    //----------------------------------------------------------------
    // Beat state
    //----------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_idx <= '0;
            wrapped  <= 1'b0;
        end else if (burst_done) begin
            beat_idx <= '0;
            wrapped  <= 1'b0;
        end else if (beat_done && head_valid) begin
            beat_idx <= beat_idx + axi_len_t'(1);
            wrapped  <= wrapped | (is_wrap & wrap_hit);
        end
    end

    always_ff @(posedge clk) begin
        if (beat_done && !beat_last) begin
            cur_addr <= next_addr;
        end
    end

    // Beat 0 takes the start address straight from the head entry
    assign beat_addr = (beat_idx == '0) ? head_addr : cur_addr;
    assign beat_last = head_valid & (beat_idx == head_len);

endmodule

`default_nettype wire

// File: logic/fetch_timer.sv
//--------------------------------------------------------------------
// FSM modelling the memory fetch delay of each beat
//--------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "axi_rd_settings.svh"

module fetch_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic head_valid,
    input  logic beat_done,
    input  logic burst_done,
    output logic beat_ready
);
    import axi_rd_pkg::*;

    localparam int DLY   = `AXI_RD_FETCH_DLY;
    localparam int CNT_W = $clog2(DLY);

    fetch_state_t     state;
    logic [CNT_W-1:0] dly_cnt;
    logic             head_chk;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= FETCH_IDLE;
            dly_cnt  <= '0;
            head_chk <= 1'b0;
        end else begin
            // Queue head advances the cycle after a burst ends
            head_chk <= burst_done;
            case (state)
                FETCH_IDLE: begin
                    // The idle cycle that sees the head already counts
                    if (head_valid) begin
                        state   <= FETCH_WAIT;
                        dly_cnt <= CNT_W'(1);
                    end
                end
                FETCH_WAIT: begin
                    if (head_chk && !head_valid) begin
                        state <= FETCH_IDLE;
                    end else if (dly_cnt == CNT_W'(DLY - 1)) begin
                        state <= FETCH_READY;
                    end else begin
                        dly_cnt <= dly_cnt + CNT_W'(1);
                    end
                end
                FETCH_READY: begin
                    // Next fetch starts on the handshake edge itself
                    if (beat_done) begin
                        state   <= FETCH_WAIT;
                        dly_cnt <= '0;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    assign beat_ready = (state == FETCH_READY);

endmodule

`default_nettype wire

// File: logic/r_channel_out.sv
//--------------------------------------------------------------------
// R channel beat assembly and completion pulses
//--------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module r_channel_out (
    // Beat sources
    input  logic                  beat_ready,
    input  axi_rd_pkg::axi_addr_t beat_addr,
    input  logic                  beat_last,
    input  axi_rd_pkg::axi_id_t   head_id,
    // R channel
    input  logic                  rready,
    output logic                  rvalid,
    output axi_rd_pkg::axi_id_t   rid,
    output axi_rd_pkg::axi_data_t rdata,
    output axi_rd_pkg::axi_resp_t rresp,
    output logic                  rlast,
    // Progress back to the address and fetch logic
    output logic                  beat_done,
    output logic                  burst_done
);
    import axi_rd_pkg::*;

    logic err_id;

    // All-ones ID marks a failing transaction
    assign err_id = &head_id;

    assign rvalid = beat_ready;
    assign rid    = head_id;
    assign rdata  = axi_data_t'({head_id, beat_addr});
    assign rresp  = (err_id && beat_last) ? RESP_SLVERR : RESP_OKAY;
    assign rlast  = beat_ready & beat_last;

    // Handshake pulses
    assign beat_done  = rvalid & rready;
    assign burst_done = beat_done & beat_last;

endmodule

`default_nettype wire

// File: logic/axi_rd_slave.sv
//--------------------------------------------------------------------
// AXI read-only slave top level with outstanding request queue
//--------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module axi_rd_slave (
    input  logic                   clk,
    input  logic                   rst_n,
    // AR channel
    input  logic                   arvalid,
    output logic                   arready,
    input  axi_rd_pkg::axi_id_t    arid,
    input  axi_rd_pkg::axi_addr_t  araddr,
    input  axi_rd_pkg::axi_len_t   arlen,
    input  axi_rd_pkg::axi_size_t  arsize,
    input  axi_rd_pkg::axi_burst_t arburst,
    // R channel
    output logic                   rvalid,
    input  logic                   rready,
    output axi_rd_pkg::axi_id_t    rid,
    output axi_rd_pkg::axi_data_t  rdata,
    output axi_rd_pkg::axi_resp_t  rresp,
    output logic                   rlast
);
    import axi_rd_pkg::*;

    logic       head_valid;
    axi_id_t    head_id;
    axi_addr_t  head_addr;
    axi_len_t   head_len;
    axi_size_t  head_size;
    axi_burst_t head_burst;
    axi_addr_t  beat_addr;
    logic       beat_last;
    logic       beat_ready;
    logic       beat_done;
    logic       burst_done;

    rd_req_queue u_req_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .arvalid    (arvalid),
        .arready    (arready),
        .arid       (arid),
        .araddr     (araddr),
        .arlen      (arlen),
        .arsize     (arsize),
        .arburst    (arburst),
        .burst_done (burst_done),
        .head_valid (head_valid),
        .head_id    (head_id),
        .head_addr  (head_addr),
        .head_len   (head_len),
        .head_size  (head_size),
        .head_burst (head_burst)
    );

    // Address and fetch timing run side by side on the head request
    beat_addr_gen u_beat_addr (
        .clk        (clk),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .head_addr  (head_addr),
        .head_len   (head_len),
        .head_size  (head_size),
        .head_burst (head_burst),
        .beat_done  (beat_done),
        .burst_done (burst_done),
        .beat_addr  (beat_addr),
        .beat_last  (beat_last)
    );

    fetch_timer u_fetch_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .beat_done  (beat_done),
        .burst_done (burst_done),
        .beat_ready (beat_ready)
    );

    r_channel_out u_r_out (
        .beat_ready (beat_ready),
        .beat_addr  (beat_addr),
        .beat_last  (beat_last),
        .head_id    (head_id),
        .rready     (rready),
        .rvalid     (rvalid),
        .rid        (rid),
        .rdata      (rdata),
        .rresp      (rresp),
        .rlast      (rlast),
        .beat_done  (beat_done),
        .burst_done (burst_done)
    );

endmodule

`default_nettype wire

// File: sim/tb_clkgen.sv
//--------------------------------------------------------------------
// Testbench clock and reset generator
//--------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
    parameter int HALF_PERIOD = 5,
    parameter int RST_CYCLES  = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Release just after an edge so no flop sees it change on the edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: sim/axi_rd_props.sv
//--------------------------------------------------------------------
// Concurrent assertions on the AXI ports, bound to the slave top
//--------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module axi_rd_props (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  rvalid,
    input logic                  rready,
    input axi_rd_pkg::axi_id_t   rid,
    input axi_rd_pkg::axi_data_t rdata,
    input axi_rd_pkg::axi_resp_t rresp,
    input logic                  rlast
);

    // A stalled beat holds its payload
    property p_r_stable;
        @(posedge clk) disable iff (!rst_n)
        (rvalid && !rready) |=> (rvalid && $stable(rid) && $stable(rdata)
                                 && $stable(rresp) && $stable(rlast));
    endproperty

    property p_rlast_with_rvalid;
        @(posedge clk) disable iff (!rst_n)
        rlast |-> rvalid;
    endproperty

    // First edge out of reset
    property p_rvalid_low_after_reset;
        @(posedge clk)
        $rose(rst_n) |-> (!rvalid && !rlast);
    endproperty

    a_r_stable: assert property (p_r_stable)
        else $error("R beat changed while rready was low");
    a_rlast_with_rvalid: assert property (p_rlast_with_rvalid)
        else $error("rlast high without rvalid");
    a_rvalid_low_after_reset: assert property (p_rvalid_low_after_reset)
        else $error("rvalid high right after reset");

endmodule

bind axi_rd_slave axi_rd_props u_props (
    .clk    (clk),
    .rst_n  (rst_n),
    .rvalid (rvalid),
    .rready (rready),
    .rid    (rid),
    .rdata  (rdata),
    .rresp  (rresp),
    .rlast  (rlast)
);

`default_nettype wire

// File: sim/tb_axi_rd_slave.sv
//--------------------------------------------------------------------
// Testbench of the AXI read slave: stimulus, reference model,
// R beat compare, watchdog and summary
//--------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "axi_rd_settings.svh"

module tb_axi_rd_slave;
    import axi_rd_pkg::*;

    logic       clk;
    logic       rst_n;
    logic       arvalid;
    logic       arready;
    axi_id_t    arid;
    axi_addr_t  araddr;
    axi_len_t   arlen;
    axi_size_t  arsize;
    axi_burst_t arburst;
    logic       rvalid;
    logic       rready;
    axi_id_t    rid;
    axi_data_t  rdata;
    axi_resp_t  rresp;
    logic       rlast;

    // Planned requests and requests accepted but not yet finished
    axi_id_t    pl_id[$];
    axi_addr_t  pl_addr[$];
    axi_len_t   pl_len[$];
    axi_size_t  pl_size[$];
    axi_burst_t pl_burst[$];
    axi_id_t    exp_id[$];
    axi_addr_t  exp_addr[$];
    axi_len_t   exp_len[$];
    axi_size_t  exp_size[$];
    axi_burst_t exp_burst[$];

    integer seed = 32'ha7d150e3;
    int     err_count = 0;
    int     total_beats = 0;
    int     beats_seen = 0;
    int     beat_idx = 0;
    int     n_accepted = 0;
    int     n_done = 0;
    logic   plan_ready = 1'b0;
    logic   rand_rready = 1'b0;
    logic   saw_full = 1'b0;
    time    ar_edge_time = 0;

    tb_clkgen u_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    axi_rd_slave u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .arvalid (arvalid),
        .arready (arready),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .rvalid  (rvalid),
        .rready  (rready),
        .rid     (rid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast)
    );

    //----------------------------------------------------------------
    // Reference model and helpers
    //----------------------------------------------------------------
    function automatic void ref_beat(
        input  axi_id_t    id,
        input  axi_addr_t  start,
        input  axi_len_t   len,
        input  axi_size_t  size,
        input  axi_burst_t burst,
        input  int         n,
        output axi_addr_t  addr,
        output axi_data_t  data,
        output axi_resp_t  resp,
        output logic       last
    );
        int bytes;
        int aligned;
        int span;
        int low;
        int lin;
        bytes   = 1 << size;
        aligned = int'(start) & ~(bytes - 1);
        span    = (int'(len) + 1) * bytes;
        low     = int'(start) & ~(span - 1);
        if (n == 0 || burst == BURST_FIXED)
            lin = int'(start);
        else if (burst == BURST_WRAP)
            lin = low + ((aligned - low + n * bytes) % span);
        else
            lin = aligned + n * bytes;
        addr = axi_addr_t'(lin);
        // ID sits right above the address bits
        data = (axi_data_t'(id) << `AXI_RD_ADDR_W) | axi_data_t'(addr);
        last = (n == int'(len));
        resp = (last && id == '1) ? RESP_SLVERR : RESP_OKAY;
    endfunction

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("ERROR @ %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic add_req(input axi_id_t id, input axi_addr_t addr, input axi_len_t len,
                           input axi_size_t size, input axi_burst_t burst);
        pl_id.push_back(id);
        pl_addr.push_back(addr);
        pl_len.push_back(len);
        pl_size.push_back(size);
        pl_burst.push_back(burst);
        total_beats += int'(len) + 1;
    endtask

    // Holds arvalid until the slave takes the request
    task automatic issue_req(input int k);
        arvalid = 1'b1;
        arid    = pl_id[k];
        araddr  = pl_addr[k];
        arlen   = pl_len[k];
        arsize  = pl_size[k];
        arburst = pl_burst[k];
        @(posedge clk);
        while (arready !== 1'b1) @(posedge clk);
        #1;
        arvalid = 1'b0;
    endtask

    // Gives up once no beat has arrived for several fetch times
    task automatic drain();
        int quiet;
        int last_beats;
        quiet      = 0;
        last_beats = beats_seen;
        while (n_done != n_accepted && quiet < 4 * (`AXI_RD_FETCH_DLY + 20)) begin
            @(posedge clk);
            #1;
            if (beats_seen != last_beats) begin
                quiet      = 0;
                last_beats = beats_seen;
            end else begin
                quiet++;
            end
        end
        repeat (3) @(posedge clk);
        #1;
    endtask

    //----------------------------------------------------------------
    // AR tracking and R beat compare
    //----------------------------------------------------------------
    always @(posedge clk) begin : track_and_compare
        axi_addr_t e_addr;
        axi_data_t e_data;
        axi_resp_t e_resp;
        logic      e_last;
        if (rst_n) begin
            if (rvalid && rready) begin
                if (exp_id.size() == 0) begin
                    err_count++;
                    $display("R beat at %0t ns arrived with no request outstanding", $time);
                end else begin
                    ref_beat(exp_id[0], exp_addr[0], exp_len[0], exp_size[0], exp_burst[0],
                             beat_idx, e_addr, e_data, e_resp, e_last);
                    check_val("rid", 32'(rid), 32'(exp_id[0]));
                    check_val("beat address", 32'(rdata[`AXI_RD_ADDR_W-1:0]), 32'(e_addr));
                    check_val("rdata", rdata, e_data);
                    check_val("rresp", 32'(rresp), 32'(e_resp));
                    check_val("rlast", 32'(rlast), 32'(e_last));
                    beats_seen++;
                    if (e_last) begin
                        void'(exp_id.pop_front());
                        void'(exp_addr.pop_front());
                        void'(exp_len.pop_front());
                        void'(exp_size.pop_front());
                        void'(exp_burst.pop_front());
                        beat_idx = 0;
                        n_done++;
                    end else begin
                        beat_idx++;
                    end
                end
            end
            if (arvalid && arready) begin
                exp_id.push_back(arid);
                exp_addr.push_back(araddr);
                exp_len.push_back(arlen);
                exp_size.push_back(arsize);
                exp_burst.push_back(arburst);
                n_accepted++;
                ar_edge_time = $time;
            end
            if (!arready)
                saw_full = 1'b1;
        end
    end

    // Random back-pressure on R, roughly one stall in four
    initial begin : drive_rready
        rready = 1'b0;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            #1;
            if (rand_rready)
                rready = (($random(seed) & 32'd3) != 32'd0);
            else
                rready = 1'b1;
        end
    end

    initial begin : watchdog
        int limit;
        wait (plan_ready === 1'b1);
        limit = (total_beats + 10) * (`AXI_RD_FETCH_DLY + 20);
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("SIMULATION FAILED");
        $finish;
    end

    //----------------------------------------------------------------
    // Stimulus
    //----------------------------------------------------------------
    initial begin : main
        int  i;
        int  p2_end;
        time lat;
        arvalid = 1'b0;
        arid    = '0;
        araddr  = '0;
        arlen   = '0;
        arsize  = '0;
        arburst = BURST_INCR;

        // Idle latency probe
        add_req(4'd0, 16'h0040, 8'd1, 3'd2, BURST_INCR);
        // INCR, one of them unaligned
        add_req(4'd1, 16'h0100, 8'd3, 3'd2, BURST_INCR);
        add_req(4'd2, 16'h0203, 8'd4, 3'd2, BURST_INCR);
        add_req(4'd3, 16'h0301, 8'd0, 3'd0, BURST_INCR);
        add_req(4'd4, 16'h0402, 8'd7, 3'd1, BURST_INCR);
        // FIXED
        add_req(4'd5, 16'h0500, 8'd3, 3'd2, BURST_FIXED);
        add_req(4'd6, 16'h0611, 8'd2, 3'd0, BURST_FIXED);
        // WRAP of 2, 4, 8 and 16 beats
        add_req(4'd7, 16'h0704, 8'd1, 3'd2, BURST_WRAP);
        add_req(4'd8, 16'h0808, 8'd3, 3'd2, BURST_WRAP);
        add_req(4'd9, 16'h0906, 8'd7, 3'd1, BURST_WRAP);
        add_req(4'd10, 16'h0a3c, 8'd15, 3'd2, BURST_WRAP);
        // Error ID
        add_req(4'd15, 16'h0f00, 8'd2, 3'd2, BURST_INCR);
        add_req(4'd15, 16'h0f80, 8'd0, 3'd2, BURST_INCR);
        p2_end = pl_id.size();
        // Back-to-back burst, twice the queue depth
        for (i = 0; i < 2 * `AXI_RD_OST_DEPTH; i++) begin
            add_req(axi_id_t'(i + 8), axi_addr_t'(32'h1000 + i * 64), axi_len_t'(i % 4),
                    3'd2, (i % 4 == 3) ? BURST_WRAP : ((i % 4 == 0) ? BURST_FIXED : BURST_INCR));
        end
        plan_ready = 1'b1;

        wait (rst_n === 1'b1);
        @(posedge clk);
        #1;
        check_val("arready after reset", 32'(arready), 32'd1);
        check_val("rvalid after reset", 32'(rvalid), 32'd0);
        check_val("rlast after reset", 32'(rlast), 32'd0);

        // First beat latency on an idle slave
        issue_req(0);
        @(posedge rvalid);
        lat = ($time - ar_edge_time) / 10;
        check_val("first beat latency", 32'(lat), 32'(`AXI_RD_FETCH_DLY));
        drain();

        rand_rready = 1'b1;
        for (i = 1; i < p2_end; i++)
            issue_req(i);
        drain();

        saw_full = 1'b0;
        for (i = p2_end; i < pl_id.size(); i++)
            issue_req(i);
        drain();
        if (!saw_full) begin
            err_count++;
            $display("arready never went low during the back-to-back requests");
        end

        check_val("requests completed", 32'(n_done), 32'(pl_id.size()));
        check_val("beats received", 32'(beats_seen), 32'(total_beats));

        $display("Run complete: %0d beats checked, %0d errors", beats_seen, err_count);
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+logic
logic/axi_rd_pkg.sv
logic/rd_req_queue.sv
logic/beat_addr_gen.sv
logic/fetch_timer.sv
logic/r_channel_out.sv
logic/axi_rd_slave.sv
sim/tb_clkgen.sv
sim/axi_rd_props.sv
sim/tb_axi_rd_slave.sv

// File: Makefile
# Verilator build and run of the AXI read slave testbench

SRCS := $(wildcard logic/*.sv logic/*.svh sim/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_axi_rd_slave
	./obj_dir/Vtb_axi_rd_slave > sim.log 2>&1; cat sim.log
	grep -q "SIMULATION PASSED" sim.log

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_axi_rd_slave: compile.f $(SRCS)
	verilator --binary --timing --assert -f compile.f \
		--top-module tb_axi_rd_slave -o Vtb_axi_rd_slave

clean:
	rm -rf obj_dir sim.log
